// File: verilog/rv_pkg.sv
package rv_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int xlen  = 32;          // data and address width
    localparam int sel_w = xlen / 8;    // byte lanes on the bus

    // ==================================================
    // instruction encodings
    // ==================================================
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_imm    = 7'b0010011,
        opc_reg    = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    // funct3 slot unused by real branches, marks jal
    localparam logic [2:0] br_always = 3'b010;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        src_a_rs1, src_a_pc, src_a_zero
    } src_a_e;

    typedef enum logic {
        src_b_rs2, src_b_imm
    } src_b_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,   // same coding as funct3[1:0]
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halted
    } state_e;

endpackage

// File: verilog/rv_regfile.sv
module rv_regfile import rv_pkg::*; #(
    parameter int reg_count = 16,
    localparam int idx_w = $clog2(reg_count)
) (
    input  logic             clk,
    input  logic [idx_w-1:0] rs1_addr,
    input  logic [idx_w-1:0] rs2_addr,
    output logic [xlen-1:0]  rs1_data,
    output logic [xlen-1:0]  rs2_data,
    input  logic [idx_w-1:0] rd_addr,
    input  logic             rd_we,
    input  logic [xlen-1:0]  rd_wdata
);

    logic [xlen-1:0] regs [reg_count];  // x0 slot never written

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];  // x0 reads zero
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (rd_we && rd_addr != '0) begin  // drop writes to x0
            regs[rd_addr] <= rd_wdata;
        end
    end

endmodule

// File: verilog/rv_exec.sv
module rv_exec import rv_pkg::*; (
    input  alu_op_e         alu_op,
    input  src_a_e          src_a,
    input  src_b_e          src_b,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] pc,
    input  logic            is_branch,
    input  logic            is_jalr,
    input  logic [2:0]      branch_funct,
    output logic [xlen-1:0] alu_result,
    output logic [xlen-1:0] next_pc
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            taken;
    logic [xlen-1:0] pc_ina;
    logic [xlen-1:0] pc_inb;
    logic [xlen-1:0] pc_sum;

    // ==================================================
    // alu
    // ==================================================
    always_comb begin
        case (src_a)
            src_a_pc:   op_a = pc;       // auipc
            src_a_zero: op_a = '0;       // lui
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b  = (src_b == src_b_rs2) ? rs2_data : imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_result = xlen'(op_a < op_b);
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);  // keeps sign
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    // ==================================================
    // branch compare and pc update
    // ==================================================
    always_comb begin
        case (branch_funct)
            3'b000:    taken = (rs1_data == rs2_data);                  // beq
            3'b001:    taken = (rs1_data != rs2_data);                  // bne
            3'b100:    taken = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:    taken = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:    taken = (rs1_data < rs2_data);                   // bltu
            3'b111:    taken = (rs1_data >= rs2_data);                  // bgeu
            br_always: taken = 1'b1;                                    // jal
            default:   taken = 1'b0;
        endcase
    end

    // one adder, operands picked per jump kind
    assign pc_ina  = is_jalr ? rs1_data : pc;
    assign pc_inb  = (is_jalr || (is_branch && taken)) ? imm : xlen'(4);
    assign pc_sum  = pc_ina + pc_inb;
    assign next_pc = {pc_sum[xlen-1:1], pc_sum[0] & ~is_jalr};  // jalr clears bit 0

endmodule

// File: verilog/rv_lsu.sv
module rv_lsu import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_req,
    input  logic             mem_we,
    input  logic [xlen-1:0]  mem_addr,
    input  mem_size_e        mem_size,
    input  logic             mem_load_unsigned,
    input  logic [xlen-1:0]  store_data,
    output logic             mem_done,
    output logic [xlen-1:0]  mem_rdata,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [xlen-1:0]  wb_adr,
    output logic [sel_w-1:0] wb_sel,
    output logic [xlen-1:0]  wb_wdata,
    input  logic [xlen-1:0]  wb_rdata,
    input  logic             wb_ack
);

    logic             start;
    logic [1:0]       lane;
    logic [sel_w-1:0] sel_d;
    logic [1:0]       lane_q;
    mem_size_e        size_q;
    logic             unsigned_q;
    logic [xlen-1:0]  rdata_sh;
    logic [xlen-1:0]  load_ext;

    assign start = mem_req && !wb_cyc && !mem_done;  // no restart in the done cycle
    assign lane  = mem_addr[1:0];

    always_comb begin
        case (mem_size)
            size_byte: sel_d = sel_w'(1) << lane;
            size_half: sel_d = sel_w'(3) << lane;
            default:   sel_d = {sel_w{1'b1}};
        endcase
    end

    // ==================================================
    // wishbone cycle
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (wb_cyc) begin
                if (wb_ack) begin  // last cycle of the transfer
                    wb_cyc   <= 1'b0;
                    wb_stb   <= 1'b0;
                    wb_we    <= 1'b0;
                    mem_done <= 1'b1;
                end
            end else if (start) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= mem_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin  // held until ack
            wb_adr     <= {mem_addr[xlen-1:2], 2'b00};
            wb_sel     <= sel_d;
            wb_wdata   <= store_data << {lane, 3'b000};  // move to addressed lanes
            lane_q     <= lane;
            size_q     <= mem_size;
            unsigned_q <= mem_load_unsigned;
        end
        if (wb_cyc && wb_ack) begin
            mem_rdata <= load_ext;
        end
    end

    // ==================================================
    // load extension
    // ==================================================
    assign rdata_sh = wb_rdata >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            size_byte: load_ext = {{24{~unsigned_q & rdata_sh[7]}}, rdata_sh[7:0]};
            size_half: load_ext = {{16{~unsigned_q & rdata_sh[15]}}, rdata_sh[15:0]};
            default:   load_ext = rdata_sh;  // lw and fetch
        endcase
    end

endmodule

// File: verilog/rv_ctrl.sv
module rv_ctrl import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0,
    parameter int reg_count = 16,
    localparam int idx_w = $clog2(reg_count)
) (
    input  logic             clk,
    input  logic             rst,
    output logic             mem_req,
    output logic             mem_we,
    output logic [xlen-1:0]  mem_addr,
    output mem_size_e        mem_size,
    output logic             mem_load_unsigned,
    input  logic             mem_done,
    input  logic [xlen-1:0]  mem_rdata,
    output logic [idx_w-1:0] rs1_addr,
    output logic [idx_w-1:0] rs2_addr,
    output logic [idx_w-1:0] rd_addr,
    output logic             rd_we,
    output logic [xlen-1:0]  rd_wdata,
    input  logic [xlen-1:0]  rs1_data,
    output alu_op_e          alu_op,
    output src_a_e           src_a,
    output src_b_e           src_b,
    output logic [xlen-1:0]  imm,
    output logic [xlen-1:0]  pc,
    output logic             is_branch,
    output logic             is_jalr,
    output logic [2:0]       branch_funct,
    input  logic [xlen-1:0]  alu_result,
    input  logic [xlen-1:0]  next_pc,
    output logic             halt,
    output logic [xlen-1:0]  halt_code
);

    state_e          state;
    logic [xlen-1:0] ir;
    logic [xlen-1:0] alu_q;   // result / address from execute
    logic [xlen-1:0] ld_q;    // extended load data
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic            rd_en, is_load, is_store, is_jump, is_ebreak;

    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  funct_to_alu = alt ? alu_sub : alu_add;
            3'b001:  funct_to_alu = alu_sll;
            3'b010:  funct_to_alu = alu_slt;
            3'b011:  funct_to_alu = alu_sltu;
            3'b100:  funct_to_alu = alu_xor;
            3'b101:  funct_to_alu = alt ? alu_sra : alu_srl;
            3'b110:  funct_to_alu = alu_or;
            default: funct_to_alu = alu_and;
        endcase
    endfunction

    // ==================================================
    // decoder
    // ==================================================
    assign opcode = opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign imm_i  = {{20{ir[31]}}, ir[31:20]};
    assign imm_s  = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b  = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u  = {ir[31:12], 12'b0};
    assign imm_j  = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        alu_op       = alu_add;
        src_a        = src_a_rs1;
        src_b        = src_b_imm;
        imm          = imm_i;
        is_branch    = 1'b0;
        is_jalr      = 1'b0;
        branch_funct = funct3;
        rd_en        = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        is_jump      = 1'b0;
        is_ebreak    = 1'b0;
        case (opcode)
            opc_lui: begin
                src_a = src_a_zero;
                imm   = imm_u;
                rd_en = 1'b1;
            end
            opc_auipc: begin
                src_a = src_a_pc;
                imm   = imm_u;
                rd_en = 1'b1;
            end
            opc_jal: begin
                imm          = imm_j;
                is_branch    = 1'b1;
                branch_funct = br_always;  // forces taken in exec
                is_jump      = 1'b1;
                rd_en        = 1'b1;
            end
            opc_jalr: begin
                is_jalr = 1'b1;
                is_jump = 1'b1;
                rd_en   = 1'b1;
            end
            opc_branch: begin
                imm       = imm_b;
                src_b     = src_b_rs2;
                is_branch = 1'b1;
            end
            opc_load: begin
                is_load = 1'b1;
                rd_en   = 1'b1;
            end
            opc_store: begin
                imm      = imm_s;
                is_store = 1'b1;
            end
            opc_imm: begin
                alu_op = funct_to_alu(funct3, ir[30] && funct3 == 3'b101);  // srai only
                rd_en  = 1'b1;
            end
            opc_reg: begin
                alu_op = funct_to_alu(funct3, ir[30]);
                src_b  = src_b_rs2;
                rd_en  = 1'b1;
            end
            opc_system: is_ebreak = ir[20];  // ecall ignored
            default: ;                        // unknown, acts as nop
        endcase
    end

    assign rs1_addr = is_ebreak ? idx_w'(10) : ir[15 +: idx_w];  // a0 for halt code
    assign rs2_addr = ir[20 +: idx_w];
    assign rd_addr  = ir[7 +: idx_w];
    assign rd_we    = (state == st_writeback) && rd_en;
    assign rd_wdata = is_load ? ld_q : (is_jump ? pc + xlen'(4) : alu_q);

    // memory request, fetch or data
    assign mem_req           = (state == st_fetch) || (state == st_memory);
    assign mem_we            = (state == st_memory) && is_store;
    assign mem_addr          = (state == st_fetch) ? pc : alu_q;
    assign mem_size          = (state == st_fetch) ? size_word : mem_size_e'(funct3[1:0]);
    assign mem_load_unsigned = funct3[2];

    // ==================================================
    // sequencer
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
            pc    <= reset_pc;
            halt  <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (mem_done) begin
                        ir    <= mem_rdata;
                        state <= st_decode;
                    end
                end
                st_decode: state <= st_execute;
                st_execute: begin
                    alu_q <= alu_result;
                    state <= (is_load || is_store) ? st_memory : st_writeback;
                end
                st_memory: begin
                    if (mem_done) begin
                        ld_q  <= mem_rdata;
                        state <= st_writeback;
                    end
                end
                st_writeback: begin
                    if (is_ebreak) begin
                        halt      <= 1'b1;
                        halt_code <= rs1_data;
                        state     <= st_halted;
                    end else begin
                        pc    <= next_pc;
                        state <= st_fetch;
                    end
                end
                default: state <= st_halted;  // parked until reset
            endcase
        end
    end

endmodule

// File: verilog/rv_core.sv
module rv_core import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0,
    parameter int reg_count = 16
) (
    input  logic             clk,
    input  logic             rst,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output logic [xlen-1:0]  wb_adr,
    output logic [sel_w-1:0] wb_sel,
    output logic [xlen-1:0]  wb_wdata,
    input  logic [xlen-1:0]  wb_rdata,
    input  logic             wb_ack,
    output logic             halt,
    output logic [xlen-1:0]  halt_code
);

    localparam int idx_w = $clog2(reg_count);

    logic             mem_req, mem_we, mem_load_unsigned, mem_done;
    logic [xlen-1:0]  mem_addr, mem_rdata;
    mem_size_e        mem_size;
    logic [idx_w-1:0] rs1_addr, rs2_addr, rd_addr;
    logic             rd_we;
    logic [xlen-1:0]  rd_wdata, rs1_data, rs2_data;
    alu_op_e          alu_op;
    src_a_e           src_a;
    src_b_e           src_b;
    logic [xlen-1:0]  imm, pc, alu_result, next_pc;
    logic             is_branch, is_jalr;
    logic [2:0]       branch_funct;

    rv_ctrl #(.reset_pc(reset_pc), .reg_count(reg_count)) u_ctrl (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_load_unsigned(mem_load_unsigned),
        .mem_done(mem_done), .mem_rdata(mem_rdata),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .rd_we(rd_we), .rd_wdata(rd_wdata), .rs1_data(rs1_data),
        .alu_op(alu_op), .src_a(src_a), .src_b(src_b), .imm(imm), .pc(pc),
        .is_branch(is_branch), .is_jalr(is_jalr), .branch_funct(branch_funct),
        .alu_result(alu_result), .next_pc(next_pc),
        .halt(halt), .halt_code(halt_code)
    );

    rv_regfile #(.reg_count(reg_count)) u_regfile (
        .clk(clk),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd_addr(rd_addr), .rd_we(rd_we), .rd_wdata(rd_wdata)
    );

    rv_exec u_exec (
        .alu_op(alu_op), .src_a(src_a), .src_b(src_b),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
        .is_branch(is_branch), .is_jalr(is_jalr), .branch_funct(branch_funct),
        .alu_result(alu_result), .next_pc(next_pc)
    );

    rv_lsu u_lsu (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_load_unsigned(mem_load_unsigned),
        .store_data(rs2_data),  // rs2 stays put through the memory state
        .mem_done(mem_done), .mem_rdata(mem_rdata),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack)
    );

endmodule

// File: bench/core_properties.sv
module core_properties import rv_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             wb_cyc,
    input logic             wb_stb,
    input logic             wb_we,
    input logic [xlen-1:0]  wb_adr,
    input logic [sel_w-1:0] wb_sel,
    input logic [xlen-1:0]  wb_wdata,
    input logic             wb_ack,
    input logic             halt
);

    timeunit 1ns;
    timeprecision 100ps;

    // ==================================================
    // wishbone rules
    // ==================================================
    a_idle_in_reset: assert property (@(posedge clk) rst |=> !wb_cyc && !wb_stb)
        else $error("bus active during reset");

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("stb without cyc");

    a_hold_lines: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr) && $stable(wb_we)
                                && $stable(wb_sel) && $stable(wb_wdata))
        else $error("bus lines moved during wait");

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else $error("halt dropped");

endmodule

bind rv_core core_properties u_props (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_wdata(wb_wdata), .wb_ack(wb_ack),
    .halt(halt)
);

// File: bench/tb_core.sv
module tb_core import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_words = 256;
    localparam int gold_base = 'hd0;  // halt code, count, then records
    localparam int max_wait  = 3;

    logic             clk;
    logic             rst;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [xlen-1:0]  wb_adr;
    logic [sel_w-1:0] wb_sel;
    logic [xlen-1:0]  wb_wdata;
    logic [xlen-1:0]  wb_rdata;
    logic             wb_ack;
    logic             halt;
    logic [xlen-1:0]  halt_code;

    logic [31:0] mem [mem_words];
    integer      seed = 13135;
    int          errors = 0;
    int          store_cnt = 0;
    int          waits = 0;
    logic        waiting = 1'b0;
    int          cycles = 0;
    int          prog_words = 0;
    int          limit = 0;

    rv_core #(.reset_pc('0), .reg_count(16)) UUT (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .halt(halt), .halt_code(halt_code)
    );

    always #2 clk = ~clk;  // 4 ns period

    // ==================================================
    // store checker
    // ==================================================
    task automatic check_store(input logic [31:0] adr, input logic [3:0] sel,
                               input logic [31:0] data);
        int idx;
        idx = gold_base + 2 + 3 * store_cnt;
        if (store_cnt >= mem[gold_base + 1]) begin  // wrong path store
            $display("mismatch at %0t: extra store adr %h sel %h data %h",
                     $time, adr, sel, data);
            errors++;
        end else if (adr !== mem[idx] || sel !== mem[idx + 1][3:0]
                     || data !== mem[idx + 2]) begin
            $display("mismatch at %0t: store %0d expected %h/%h/%h got %h/%h/%h",
                     $time, store_cnt, mem[idx], mem[idx + 1][3:0], mem[idx + 2],
                     adr, sel, data);
            errors++;
        end
        store_cnt++;
    endtask

    task automatic write_lanes(input logic [31:0] adr, input logic [3:0] sel,
                               input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                mem[adr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // ==================================================
    // wishbone slave model
    // ==================================================
    always @(negedge clk) begin
        if (rst) begin
            wb_ack  = 1'b0;
            waiting = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;  // core dropped cyc on the ack edge
        end else if (wb_cyc && wb_stb) begin
            if (!waiting) begin
                waits   = $random(seed) & max_wait;  // 0 to 3 wait states
                waiting = 1'b1;
            end
            if (waits == 0) begin
                waiting = 1'b0;
                wb_ack  = 1'b1;
                if (wb_we) begin
                    check_store(wb_adr, wb_sel, wb_wdata);
                    write_lanes(wb_adr, wb_sel, wb_wdata);
                end else begin
                    wb_rdata = mem[wb_adr[9:2]];
                end
            end else begin
                waits--;
            end
        end
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_ack   = 1'b0;
        wb_rdata = '0;
        $readmemh("bench/core_golden.hex", mem);
        while (prog_words < gold_base && mem[prog_words] != 0) begin
            prog_words++;  // program runs until the first empty word
        end
        limit = prog_words * (12 + max_wait) * 2;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (!halt && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("timeout: core never halted after %0d cycles", cycles);
            errors++;
        end else begin
            repeat (4) begin  // bus stays quiet once halted
                @(negedge clk);
                if (wb_cyc || wb_stb) begin
                    $display("bus still active after halt at %0t", $time);
                    errors++;
                end
            end
            if (halt_code !== mem[gold_base]) begin
                $display("mismatch at %0t: halt code expected %h got %h",
                         $time, mem[gold_base], halt_code);
                errors++;
            end
            if (store_cnt < mem[gold_base + 1]) begin
                $display("missing store records: expected %0d, saw %0d",
                         mem[gold_base + 1], store_cnt);
                errors++;
            end
        end
        $display("errors: %0d stores: %0d cycles: %0d", errors, store_cnt, cycles);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: bench/core_golden.hex
// words 0x00..: program image, one instruction per word
// 0xc0: load data, 0xd0: halt code, 0xd1: store count, 0xd2..: adr sel data
@0
20000093 FF800113 40115193 0030A023 // base, -8, srai, store
00500213 004122B3 00413333 0050A223 // slt and sltu
0060A423 123453B7 00001417 0083C4B3 // lui auipc xor
0090A623 009088A3 00909B23 30000513 // sw sb sh, load base
00050583 00255603 00251683 00054703 // lb lhu lh lbu
00B0AC23 00C0AE23 02D0A023 02E0A223 // store loads back
00414463 0200A423 00416463 0240A423 // blt taken, bltu not taken
008007EF 0200A623 01078067 0200A623 // jal, jalr
0200A623 02F0A623 00100073          // link marker, ebreak
@c0
F0807F85
@d0
00000300 0000000C
00000200 F FFFFFFFC
00000204 F 00000001
00000208 F 00000000
0000020C F 12344028
00000210 2 34402800
00000214 C 40280000
00000218 F FFFFFF85
0000021C F 0000F080
00000220 F FFFFF080
00000224 F 00000085
00000228 F 00000005
0000022C F 00000074

// File: tb.f
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_exec.sv
verilog/rv_lsu.sv
verilog/rv_ctrl.sv
verilog/rv_core.sv
bench/core_properties.sv
bench/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
